// ==== logic/radio_ctrl_pkg.sv ====
// Shared types and constants for the dsp_clk control plane.
// Settings bus writes are single-cycle strobes with no handshake.
// Register addresses not listed in sr_addr_e are ignored by every block.
// COMPAT_NUM must change whenever the register map changes.

package radio_ctrl_pkg;

   //////////////////////////////////////////////////
   // Settings bus

   typedef struct packed {
      logic        stb;   // One-cycle write strobe
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef enum logic [7:0] {
      SR_MISC_CLOCK   = 8'd0,
      SR_MISC_ADC     = 8'd2,
      SR_MISC_LED_SW  = 8'd3,
      SR_MISC_PHY     = 8'd4,
      SR_MISC_LED_SRC = 8'd6,
      SR_TIME_SECS    = 8'd10,
      SR_TIME_TICKS   = 8'd11,
      SR_TIME_CTRL    = 8'd12   // Bit 0 set loads at once, clear waits for PPS
   } sr_addr_e;

   //////////////////////////////////////////////////
   // Board control outputs

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   //////////////////////////////////////////////////
   // Time and status

   typedef struct packed {
      logic [31:0] secs;    // Upper readback word
      logic [31:0] ticks;   // Lower readback word
   } vita_time_t;

   typedef enum logic [1:0] {
      LOAD_IDLE   = 2'd0,
      LOAD_NOW    = 2'd1,
      LOAD_AT_PPS = 2'd2
   } time_load_e;

   typedef struct packed {
      logic [27:0] rsvd;    // Always zero
      logic        pps_int;
      logic        phy_int;
      logic        clk_status;
      logic        button;
   } irq_status_t;

   localparam logic [31:0] COMPAT_NUM    = {16'd7, 16'd1};  // Major, minor
   localparam logic [7:0]  LED_SRC_RESET = 8'b0001_1110;    // HW on bits 1 to 4

endpackage

// ==== logic/misc_ctrl_regs.sv ====
`timescale 1ns/1ps
// Misc board settings and LED source selection.
// Only the low bits of each settings word are kept; the rest are dropped.
// phy_resetn_o follows the written bit directly, so 0 holds the PHY in reset.
// LEDs are combinational from the registers and the status inputs.

module misc_ctrl_regs
   import radio_ctrl_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        por_rst,

   input  set_bus_t    set_bus_i,

   input  logic        run_rx_i,
   input  logic        run_tx_i,
   input  logic        clk_status_i,
   input  logic        good_sync_i,

   output clock_ctrl_t clock_ctrl_o,
   output adc_ctrl_t   adc_ctrl_o,
   output logic        phy_resetn_o,
   output logic [7:0]  leds_o
);

   logic [7:0] led_sw_r;    // Software LED value
   logic [7:0] led_src_r;   // 1 = hardware, 0 = software
   logic [7:0] led_hw;

   //////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ctrl_o <= '0;
         adc_ctrl_o   <= '0;
         phy_resetn_o <= 1'b0;   // PHY held in reset until software releases it
         led_sw_r     <= '0;
         led_src_r    <= LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SR_MISC_CLOCK: begin
               clock_ctrl_o <= clock_ctrl_t'(set_bus_i.data[4:0]);
            end
            SR_MISC_ADC: begin
               adc_ctrl_o <= adc_ctrl_t'(set_bus_i.data[3:0]);
            end
            SR_MISC_LED_SW: begin
               led_sw_r <= set_bus_i.data[7:0];
            end
            SR_MISC_PHY: begin
               phy_resetn_o <= set_bus_i.data[0];
            end
            SR_MISC_LED_SRC: begin
               led_src_r <= set_bus_i.data[7:0];
            end
            default: begin
               // Address owned by another block
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // LED mux

   // Hardware status vector with bit 0 and bits 5-7 unused
   assign led_hw = {3'b000,
                    run_tx_i,
                    run_rx_i,
                    clk_status_i,
                    good_sync_i,
                    1'b0};

   // Per-bit select between hardware and software
   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

endmodule

// ==== logic/vita_timekeeper.sv ====
`timescale 1ns/1ps
// 64-bit VITA time, seconds in the upper word and ticks in the lower.
// TICKS_PER_SEC must be 2 or more. A loaded ticks value at or above
// TICKS_PER_SEC-1 wraps on the next count.
// pps_i is asynchronous and goes through a two-flop synchronizer, so the
// PPS latch and a PPS-armed load land three cycles after the pin edge.

module vita_timekeeper
   import radio_ctrl_pkg::*;
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  logic       dsp_clk,
   input  logic       por_rst,

   input  set_bus_t   set_bus_i,
   input  logic       pps_i,

   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       good_sync_o
);

   logic       pps_meta;
   logic       pps_sync;
   logic       pps_sync_d;
   logic       pps_edge;      // One cycle per rising PPS

   logic       ctrl_wr;
   logic       load_hit;
   time_load_e load_state;
   vita_time_t staged_time;
   vita_time_t time_inc;
   vita_time_t time_next;

   //////////////////////////////////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_sync_d <= 1'b0;
      end else begin
         pps_meta   <= pps_i;
         pps_sync   <= pps_meta;
         pps_sync_d <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_sync_d;

   //////////////////////////////////////////////////
   // Staged time and load FSM

   assign ctrl_wr = set_bus_i.stb && (set_bus_i.addr == SR_TIME_CTRL);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         staged_time <= '0;
      end else if (set_bus_i.stb) begin
         if (set_bus_i.addr == SR_TIME_SECS)
            staged_time.secs <= set_bus_i.data;
         if (set_bus_i.addr == SR_TIME_TICKS)
            staged_time.ticks <= set_bus_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         load_state <= LOAD_IDLE;
      end else if (ctrl_wr) begin
         load_state <= set_bus_i.data[0] ? LOAD_NOW : LOAD_AT_PPS;   // Rearm wins
      end else begin
         case (load_state)
            LOAD_NOW:    load_state <= LOAD_IDLE;
            LOAD_AT_PPS: if (pps_edge) load_state <= LOAD_IDLE;
            default:     load_state <= LOAD_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Counter and PPS latch

   always_comb begin
      time_inc = vita_time_o;
      if (vita_time_o.ticks >= TICKS_PER_SEC - 32'd1) begin
         time_inc.ticks = '0;
         time_inc.secs  = vita_time_o.secs + 32'd1;
      end else begin
         time_inc.ticks = vita_time_o.ticks + 32'd1;
      end
   end

   assign load_hit  = (load_state == LOAD_NOW) || ((load_state == LOAD_AT_PPS) && pps_edge);
   assign time_next = load_hit ? staged_time : time_inc;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         vita_time_o <= time_next;
         pps_int_o   <= pps_edge;
         if (pps_edge)
            vita_time_pps_o <= time_next;   // Same value the counter takes
         if ((load_state == LOAD_AT_PPS) && pps_edge)
            good_sync_o <= 1'b1;            // Sticky until reset
      end
   end

endmodule

// ==== logic/status_readback.sv ====
`timescale 1ns/1ps
// Registered 16-word status readback.
// Data and ack appear the cycle after the strobe; a read may issue every cycle.
// rb_data_o holds the last word read and is undefined before the first read.

module status_readback
   import radio_ctrl_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        por_rst,

   input  logic        rb_stb_i,
   input  logic [3:0]  rb_addr_i,

   input  vita_time_t  vita_time_i,
   input  vita_time_t  vita_time_pps_i,
   input  irq_status_t irq_i,

   output logic [31:0] rb_data_o,
   output logic        rb_ack_o
);

   logic [31:0] rb_word;

   // Unlisted indices read zero
   always_comb begin
      case (rb_addr_i)
         4'd10:   rb_word = vita_time_i.secs;
         4'd11:   rb_word = vita_time_i.ticks;
         4'd12:   rb_word = COMPAT_NUM;
         4'd13:   rb_word = irq_i;
         4'd14:   rb_word = vita_time_pps_i.secs;
         4'd15:   rb_word = vita_time_pps_i.ticks;
         default: rb_word = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // Output register

   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i)
         rb_data_o <= rb_word;   // Held until the next strobe
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         rb_ack_o <= 1'b0;
      else
         rb_ack_o <= rb_stb_i;   // One pulse per strobe
   end

endmodule

// ==== logic/radio_ctrl_core.sv ====
`timescale 1ns/1ps
// dsp_clk control plane: settings registers, LEDs, VITA time and readback.
// Everything runs on dsp_clk; pps_i is the only asynchronous input.
// run_rx_i, run_tx_i and the status inputs are assumed already synchronous.
// TICKS_PER_SEC sets the tick rate of the time counter.

module radio_ctrl_core
   import radio_ctrl_pkg::*;
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  logic        dsp_clk,
   input  logic        por_rst,

   input  set_bus_t    set_bus_i,

   input  logic        pps_i,
   input  logic        run_rx_i,
   input  logic        run_tx_i,
   input  logic        clk_status_i,
   input  logic        phy_int_n_i,
   input  logic        button_i,

   input  logic        rb_stb_i,
   input  logic [3:0]  rb_addr_i,
   output logic [31:0] rb_data_o,
   output logic        rb_ack_o,

   output logic [7:0]  leds_o,
   output clock_ctrl_t clock_ctrl_o,
   output adc_ctrl_t   adc_ctrl_o,
   output logic        phy_resetn_o
);

   vita_time_t  vita_time;
   vita_time_t  vita_time_pps;
   logic        pps_int;
   logic        good_sync;
   irq_status_t irq;

   //////////////////////////////////////////////////
   // Misc registers and LEDs

   misc_ctrl_regs misc_regs_i (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_bus_i    (set_bus_i),
      .run_rx_i     (run_rx_i),
      .run_tx_i     (run_tx_i),
      .clk_status_i (clk_status_i),
      .good_sync_i  (good_sync),
      .clock_ctrl_o (clock_ctrl_o),
      .adc_ctrl_o   (adc_ctrl_o),
      .phy_resetn_o (phy_resetn_o),
      .leds_o       (leds_o)
   );

   //////////////////////////////////////////////////
   // VITA time

   vita_timekeeper #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) timekeeper_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_bus_i       (set_bus_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int),
      .good_sync_o     (good_sync)
   );

   //////////////////////////////////////////////////
   // Status word and readback

   // PHY interrupt pin is open drain, active low
   assign irq = '{rsvd: '0, pps_int: pps_int, phy_int: ~phy_int_n_i,
                  clk_status: clk_status_i, button: button_i};

   status_readback readback_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .irq_i           (irq),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

endmodule

// ==== testbench/tb_radio_ctrl_core.sv ====
`timescale 1ns/1ps
// Testbench for radio_ctrl_core with a 50-tick second.
// Inputs change on the falling clock edge and outputs are sampled there.
// pps_i reaches the counter three cycles after its pin edge.

module tb_radio_ctrl_core
   import radio_ctrl_pkg::*;
();

   localparam int          MAX_CYCLES    = 4000;
   localparam logic [7:0]  RESET_LED_SRC = 8'b0001_1110;        // HW on bits 1 to 4
   localparam logic [31:0] EXP_COMPAT    = {16'd7, 16'd1};      // Major 7, minor 1

   logic        dsp_clk;
   logic        por_rst;
   set_bus_t    set_bus;
   logic        pps;
   logic        run_rx;
   logic        run_tx;
   logic        clk_status;
   logic        phy_int_n;
   logic        button;
   logic        rb_stb;
   logic [3:0]  rb_addr;
   logic [31:0] rb_data;
   logic        rb_ack;
   logic [7:0]  leds;
   clock_ctrl_t clock_ctrl;
   adc_ctrl_t   adc_ctrl;
   logic        phy_resetn;

   integer seed;
   int     errors       = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     test_start   = 0;
   int     cycles       = 0;

   radio_ctrl_core #(.TICKS_PER_SEC(32'd50)) dut_i (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_bus_i    (set_bus),
      .pps_i        (pps),
      .run_rx_i     (run_rx),
      .run_tx_i     (run_tx),
      .clk_status_i (clk_status),
      .phy_int_n_i  (phy_int_n),
      .button_i     (button),
      .rb_stb_i     (rb_stb),
      .rb_addr_i    (rb_addr),
      .rb_data_o    (rb_data),
      .rb_ack_o     (rb_ack),
      .leds_o       (leds),
      .clock_ctrl_o (clock_ctrl),
      .adc_ctrl_o   (adc_ctrl),
      .phy_resetn_o (phy_resetn)
   );

   always #50 dsp_clk = ~dsp_clk;   // 100 ns period

   // Run limit well above the total test length
   always @(posedge dsp_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles without finishing the tests", cycles);
         $display("test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Checks and bus tasks

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      assert (ok) else begin
         $display("ERROR at %0d ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start) begin
         $display("%-16s ok", name);
      end else begin
         tests_failed++;
         $display("%-16s %0d check(s) failed", name, errors - test_start);
      end
      test_start = errors;
   endtask

   // One strobe cycle; the register shows the value at the returning edge
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_bus = '{stb: 1'b1, addr: addr, data: data};
      @(negedge dsp_clk);
      set_bus.stb = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
      @(negedge dsp_clk);
      rb_stb  = 1'b1;
      rb_addr = addr;
      @(negedge dsp_clk);
      rb_stb = 1'b0;
      assert (rb_ack === 1'b1) else begin
         $display("Readback of word %0d got no acknowledge one cycle after its strobe", addr);
         errors++;
      end
      data = rb_data;
      @(negedge dsp_clk);
      assert (rb_ack === 1'b0) else begin
         $display("Readback acknowledge of word %0d lasted more than one cycle", addr);
         errors++;
      end
   endtask

   // Source bit 1 picks the hardware bit, 0 the software bit
   function automatic logic [7:0] expected_leds(input logic [7:0] src, input logic [7:0] sw,
                                                input logic [7:0] hw);
      logic [7:0] led;
      for (int b = 0; b < 8; b++)
         led[b] = src[b] ? hw[b] : sw[b];
      return led;
   endfunction

   //////////////////////////////////////////////////
   // Stimulus

   initial begin : stimulus
      logic [31:0] data;
      logic [31:0] rd;
      logic [7:0]  src;
      logic [7:0]  sw;
      logic [7:0]  hw;

      seed      = 32'h130a;
      dsp_clk   = 1'b0;
      por_rst   = 1'b1;
      set_bus   = '0;
      pps       = 1'b0;
      run_rx    = 1'b1;
      run_tx    = 1'b0;
      clk_status = 1'b1;
      phy_int_n = 1'b1;
      button    = 1'b0;
      rb_stb    = 1'b0;
      rb_addr   = '0;
      repeat (10) @(negedge dsp_clk);
      por_rst = 1'b0;

      // Reset state while good_sync is still low
      @(negedge dsp_clk);
      hw = {3'b000, run_tx, run_rx, clk_status, 1'b0, 1'b0};
      check_equal("leds_o", leds, expected_leds(RESET_LED_SRC, 8'h00, hw));
      check_equal("clock_ctrl_o", {27'd0, clock_ctrl}, 32'd0);
      check_equal("adc_ctrl_o", {28'd0, adc_ctrl}, 32'd0);
      check_equal("phy_resetn_o", {31'd0, phy_resetn}, 32'd0);
      end_test("reset_state");

      // Misc registers and LED mux
      for (int i = 0; i < 8; i++) begin
         data = $random(seed);
         write_setting(SR_MISC_CLOCK, data);
         check_equal("clock_ctrl_o", {27'd0, clock_ctrl}, {27'd0, data[4:0]});
         data = $random(seed);
         write_setting(SR_MISC_ADC, data);
         check_equal("adc_ctrl_o", {28'd0, adc_ctrl}, {28'd0, data[3:0]});
         data = $random(seed);
         write_setting(SR_MISC_PHY, data);
         check_equal("phy_resetn_o", {31'd0, phy_resetn}, {31'd0, data[0]});
         data = $random(seed);
         run_rx     = data[0];
         run_tx     = data[1];
         clk_status = data[2];
         src = $random(seed);
         sw  = $random(seed);
         write_setting(SR_MISC_LED_SRC, {24'd0, src});
         write_setting(SR_MISC_LED_SW, {24'd0, sw});
         hw = {3'b000, run_tx, run_rx, clk_status, 1'b0, 1'b0};
         check_equal("leds_o", leds, expected_leds(src, sw, hw));
      end
      write_setting(SR_MISC_LED_SRC, {24'd0, RESET_LED_SRC});   // Back to hardware LEDs
      end_test("misc_regs");

      // Readback constants and interrupt status
      for (int w = 0; w < 10; w++) begin
         read_word(w[3:0], rd);
         check_equal($sformatf("readback word %0d", w), rd, 32'd0);
      end
      read_word(4'd12, rd);
      check_equal("compat number", rd, EXP_COMPAT);
      for (int i = 0; i < 6; i++) begin
         data = $random(seed);
         phy_int_n  = data[0];
         clk_status = data[1];
         button     = data[2];
         read_word(4'd13, rd);
         check_equal("irq word", rd, {28'd0, 1'b0, ~data[0], data[1], data[2]});
      end
      end_test("readback");

      // Immediate load of 5:47 that wraps to second 6 after three counts
      write_setting(SR_TIME_SECS, 32'd5);
      write_setting(SR_TIME_TICKS, 32'd47);
      write_setting(SR_TIME_CTRL, 32'd1);
      repeat (10) @(negedge dsp_clk);
      read_word(4'd10, rd);
      check_equal("time secs", rd, 32'd6);
      read_word(4'd11, rd);
      check_true(rd < 32'd50, $sformatf("time ticks %0d not below 50", rd));
      end_test("time_load_now");

      // PPS-armed load of 20:0
      write_setting(SR_TIME_SECS, 32'd20);
      write_setting(SR_TIME_TICKS, 32'd0);
      write_setting(SR_TIME_CTRL, 32'd0);
      read_word(4'd10, rd);
      check_true(rd < 32'd20, $sformatf("time secs %0d reached 20 before the PPS", rd));
      pps = 1'b1;
      repeat (2) @(negedge dsp_clk);   // Strobe lands in the pps_int cycle
      read_word(4'd13, rd);
      check_equal("irq word at PPS", rd, {28'd0, 1'b1, ~phy_int_n, clk_status, button});
      pps = 1'b0;
      read_word(4'd14, rd);
      check_equal("PPS secs", rd, 32'd20);
      read_word(4'd15, rd);
      check_equal("PPS ticks", rd, 32'd0);
      read_word(4'd10, rd);
      check_equal("time secs", rd, 32'd20);
      check_true(leds[1] === 1'b1, "good_sync LED is not lit after the PPS-armed load");
      end_test("pps_load");

      $display("Summary: %0d tests run, %0d with errors, %0d checks failed",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== all.f ====
logic/radio_ctrl_pkg.sv
logic/misc_ctrl_regs.sv
logic/vita_timekeeper.sv
logic/status_readback.sv
logic/radio_ctrl_core.sv
testbench/tb_radio_ctrl_core.sv

// ==== Bender.yml ====
package:
  name: radio_ctrl_core

sources:
  - logic/radio_ctrl_pkg.sv
  - logic/misc_ctrl_regs.sv
  - logic/vita_timekeeper.sv
  - logic/status_readback.sv
  - logic/radio_ctrl_core.sv
  - target: test
    files:
      - testbench/tb_radio_ctrl_core.sv
